//--- run_sim.sh
#!/bin/sh
# Compile and run the mopshub_lite testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f vlog.f --top-module tb_mopshub_lite -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Keep running after an assertion error so the testbench reports it
out=$(./obj_dir/Vtb_mopshub_lite +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TEST PASS"; then
  exit 0
fi
exit 1

//--- sim/mopshub_lite_chk.sv
`default_nettype none
`include "hub_macros.svh"

module mopshub_lite_chk (
  input logic                    clk_40,
  input logic                    rst,
  input logic [7:0]              paddr,
  input logic                    psel,
  input logic                    penable,
  input logic                    pwrite,
  input logic [31:0]             prdata,
  input logic                    pready,
  input logic                    pslverr,
  input logic [`HUB_N_BUSES-1:0] tx,
  input logic                    irq
);

  int unsigned fail_count = 0;

  // Zero wait states
  assert property (@(posedge clk_40) disable iff (!rst) pready)
  else
  begin
    $error("pready went low");
    fail_count++;
  end

  // irq follows the tx_done and rx_valid flags seen on a STATUS read
  assert property (@(posedge clk_40) disable iff (!rst)
    (psel && penable && !pwrite && paddr == `HUB_REG_STATUS) |->
      (irq == (prdata[1] | prdata[2])))
  else
  begin
    $error("irq does not match STATUS flags");
    fail_count++;
  end

  // Only the selected line may leave idle
  assert property (@(posedge clk_40) disable iff (!rst) $onehot0(~tx))
  else
  begin
    $error("more than one tx line active");
    fail_count++;
  end

  assert property (@(posedge clk_40) disable iff (!rst) pslverr |-> (psel && penable))
  else
  begin
    $error("pslverr outside an access cycle");
    fail_count++;
  end

endmodule

bind mopshub_lite mopshub_lite_chk u_chk (
  .clk_40  (clk_40),
  .rst     (rst),
  .paddr   (paddr),
  .psel    (psel),
  .penable (penable),
  .pwrite  (pwrite),
  .prdata  (prdata),
  .pready  (pready),
  .pslverr (pslverr),
  .tx      (tx),
  .irq     (irq)
);

`default_nettype wire

//--- sim/tb_mopshub_lite.sv
`default_nettype none
`include "hub_macros.svh"

module tb_mopshub_lite import hub_pkg::*; ();

  localparam int FRAME_CYCLES = `HUB_FRAME_BITS * `HUB_BIT_CYCLES;
  // Eight frames, idle waits and APB polling fit in ten frame times
  localparam int TRAFFIC = 10 * FRAME_CYCLES;
  localparam int MAX_CYCLES = 2 * TRAFFIC + 400;

  logic                    clk_40;
  logic                    rst;
  logic [7:0]              paddr;
  logic                    psel;
  logic                    penable;
  logic                    pwrite;
  logic [31:0]             pwdata;
  logic [31:0]             prdata;
  logic                    pready;
  logic                    pslverr;
  logic [`HUB_N_BUSES-1:0] tx;
  logic [`HUB_N_BUSES-1:0] rx;
  logic                    irq;
  int                      errors = 0;
  int                      tests_run = 0;
  int                      tests_failed = 0;
  int                      cycles = 0;

  mopshub_lite UUT (
    .clk_40  (clk_40),
    .rst     (rst),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .tx      (tx),
    .rx      (rx),
    .irq     (irq)
  );

  initial
  begin
    clk_40 = 1'b0;
    forever #2 clk_40 = ~clk_40;
  end

  // Run limit
  always @(posedge clk_40)
  begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES)
    begin
      $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("TEST FAIL");
      $finish;
    end
  end

  task check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task check_msg(input string what, input hub_msg_t got, input hub_msg_t exp);
    if (got !== exp)
    begin
      $display("ERROR %0t: %s is id %h data %h, expected id %h data %h",
               $time, what, got.cob_id, got.data, exp.cob_id, exp.data);
      errors++;
    end
  endtask

  task check_bit(input string what, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("ERROR %0t: %s is %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task finish_test(input string name, input int errs_at_start);
    tests_run++;
    if (errors == errs_at_start)
      $display("%s: passed", name);
    else
    begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, errors - errs_at_start);
    end
  endtask

  // Outputs are sampled in the middle of the access cycle
  task apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
    @(posedge clk_40);
    psel   <= 1'b1;
    pwrite <= 1'b1;
    paddr  <= addr;
    pwdata <= data;
    @(posedge clk_40);
    penable <= 1'b1;
    @(negedge clk_40);
    err = pslverr;
    @(posedge clk_40);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
    @(posedge clk_40);
    psel   <= 1'b1;
    pwrite <= 1'b0;
    paddr  <= addr;
    @(posedge clk_40);
    penable <= 1'b1;
    @(negedge clk_40);
    data = prdata;
    err  = pslverr;
    @(posedge clk_40);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task write_reg(input logic [7:0] addr, input logic [31:0] data);
    logic err;
    apb_write(addr, data, err);
    check_bit("pslverr on register write", err, 1'b0);
  endtask

  task expect_reg(input string what, input logic [7:0] addr, input logic [31:0] exp);
    logic [31:0] data;
    logic        err;
    apb_read(addr, data, err);
    check_bit("pslverr on register read", err, 1'b0);
    check_word(what, data, exp);
  endtask

  task issue(input hub_cmd_e op, input logic [`HUB_BUS_W-1:0] bus, output logic err);
    logic [31:0] word;
    word = '0;
    word[1:0] = op;
    word[4 +: `HUB_BUS_W] = bus;
    apb_write(`HUB_REG_CTRL, word, err);
  endtask

  task load_msg(input hub_msg_t msg);
    write_reg(`HUB_REG_TX_ID, {21'b0, msg.cob_id});
    write_reg(`HUB_REG_TX_DATA, msg.data);
  endtask

  task read_rx_msg(output hub_msg_t msg);
    logic [31:0] id_word;
    logic [31:0] data_word;
    logic        err;
    apb_read(`HUB_REG_RX_ID, id_word, err);
    check_bit("pslverr on RX_ID read", err, 1'b0);
    apb_read(`HUB_REG_RX_DATA, data_word, err);
    check_bit("pslverr on RX_DATA read", err, 1'b0);
    msg = {id_word[10:0], data_word};
  endtask

  // Poll STATUS until a flag comes up
  task wait_status(input int bit_idx, input string what);
    logic [31:0] st;
    logic        err;
    int          polls;
    polls = 0;
    apb_read(`HUB_REG_STATUS, st, err);
    while (!st[bit_idx] && polls < 64)
    begin
      apb_read(`HUB_REG_STATUS, st, err);
      polls++;
    end
    check_bit("pslverr on STATUS poll", err, 1'b0);
    if (!st[bit_idx])
    begin
      $display("Gave up waiting for %s to be set in STATUS", what);
      errors++;
    end
  endtask

  // Bus node transmitter sending the start bit, the message MSB first and the stop bit
  task send_frame(input logic [`HUB_BUS_W-1:0] bus, input hub_msg_t msg, input logic stop);
    logic [`HUB_FRAME_BITS-1:0] frame;
    frame = {1'b0, msg, stop};
    for (int i = `HUB_FRAME_BITS - 1; i >= 0; i--)
    begin
      @(posedge clk_40);
      rx[bus] <= frame[i];
      repeat (`HUB_BIT_CYCLES - 1) @(posedge clk_40);
    end
    @(posedge clk_40);
    rx[bus] <= 1'b1;
  endtask

  // Bus node receiver sampling each bit near its middle
  task capture_frame(input logic [`HUB_BUS_W-1:0] bus, output hub_msg_t msg);
    logic [`HUB_FRAME_BITS-1:0] frame;
    logic [`HUB_N_BUSES-1:0]    others;
    int                         waited;
    waited = 0;
    frame = '1;
    @(negedge clk_40);
    while (tx[bus] !== 1'b0 && waited < 16)
    begin
      @(negedge clk_40);
      waited++;
    end
    if (tx[bus] !== 1'b0)
    begin
      $display("No start bit appeared on tx line %0d", bus);
      errors++;
    end
    else
    begin
      repeat (2) @(negedge clk_40);
      for (int i = `HUB_FRAME_BITS - 1; i >= 0; i--)
      begin
        frame[i] = tx[bus];
        others = tx;
        others[bus] = 1'b1;
        check_bit("unselected tx lines high", &others, 1'b1);
        repeat (`HUB_BIT_CYCLES) @(negedge clk_40);
      end
    end
    check_bit("start bit", frame[`HUB_FRAME_BITS-1], 1'b0);
    check_bit("stop bit", frame[0], 1'b1);
    msg = frame[`HUB_FRAME_BITS-2:1];
  endtask

  function hub_msg_t rand_msg();
    hub_msg_t m;
    m.cob_id = 11'($urandom);
    m.data = $urandom;
    return m;
  endfunction

  function logic [`HUB_BUS_W-1:0] rand_bus();
    return `HUB_BUS_W'($urandom % `HUB_N_BUSES);
  endfunction

  task test_reset();
    logic [31:0] data;
    logic        err;
    int          errs;
    errs = errors;
    expect_reg("STATUS after reset", `HUB_REG_STATUS, 32'h0);
    check_bit("irq after reset", irq, 1'b0);
    check_bit("all tx lines high", &tx, 1'b1);
    apb_read(8'h1C, data, err);
    check_bit("pslverr on unmapped read", err, 1'b1);
    finish_test("reset_state", errs);
  endtask

  task test_send();
    hub_msg_t                msg;
    hub_msg_t                got;
    logic [`HUB_BUS_W-1:0]   bus;
    logic                    err;
    int                      errs;
    errs = errors;
    msg = rand_msg();
    bus = rand_bus();
    load_msg(msg);
    issue(CMD_SEND, bus, err);
    check_bit("pslverr on SEND", err, 1'b0);
    capture_frame(bus, got);
    check_msg("frame on tx line", got, msg);
    wait_status(1, "tx_done");
    check_bit("irq after send", irq, 1'b1);
    expect_reg("STATUS after send", `HUB_REG_STATUS, 32'h2);
    write_reg(`HUB_REG_STATUS, 32'h2);
    expect_reg("STATUS after clear", `HUB_REG_STATUS, 32'h0);
    check_bit("irq after clear", irq, 1'b0);
    finish_test("send_frame", errs);
  endtask

  task test_listen();
    hub_msg_t              msg;
    hub_msg_t              got;
    logic [`HUB_BUS_W-1:0] bus;
    logic [`HUB_BUS_W-1:0] other;
    logic                  err;
    int                    errs;
    errs = errors;
    msg = rand_msg();
    bus = rand_bus();
    other = bus + `HUB_BUS_W'(1 + $urandom % (`HUB_N_BUSES - 1));
    issue(CMD_LISTEN, bus, err);
    check_bit("pslverr on LISTEN", err, 1'b0);
    repeat (2) @(posedge clk_40);
    send_frame(bus, msg, 1'b1);
    wait_status(2, "rx_valid");
    check_bit("irq after receive", irq, 1'b1);
    expect_reg("STATUS after receive", `HUB_REG_STATUS, 32'h5);
    // Frame on a bus nobody listens to
    send_frame(other, rand_msg(), 1'b1);
    repeat (8) @(posedge clk_40);
    expect_reg("STATUS after foreign frame", `HUB_REG_STATUS, 32'h5);
    read_rx_msg(got);
    check_msg("RX registers", got, msg);
    expect_reg("STATUS after RX_DATA read", `HUB_REG_STATUS, 32'h1);
    check_bit("irq after RX_DATA read", irq, 1'b0);
    // A frame with a bad stop bit is dropped
    send_frame(bus, rand_msg(), 1'b0);
    repeat (8) @(posedge clk_40);
    expect_reg("STATUS after bad stop bit", `HUB_REG_STATUS, 32'h1);
    read_rx_msg(got);
    check_msg("RX registers after bad stop bit", got, msg);
    issue(CMD_ABORT, bus, err);
    check_bit("pslverr on ABORT", err, 1'b0);
    expect_reg("STATUS after ABORT", `HUB_REG_STATUS, 32'h0);
    finish_test("listen_receive", errs);
  endtask

  task test_overrun();
    hub_msg_t              first;
    hub_msg_t              second;
    hub_msg_t              got;
    logic [`HUB_BUS_W-1:0] bus;
    logic                  err;
    int                    errs;
    errs = errors;
    first = rand_msg();
    second = rand_msg();
    bus = rand_bus();
    issue(CMD_LISTEN, bus, err);
    check_bit("pslverr on LISTEN", err, 1'b0);
    repeat (2) @(posedge clk_40);
    send_frame(bus, first, 1'b1);
    wait_status(2, "rx_valid");
    send_frame(bus, second, 1'b1);
    wait_status(3, "overrun");
    expect_reg("STATUS after overrun", `HUB_REG_STATUS, 32'hD);
    read_rx_msg(got);
    check_msg("RX registers after overrun", got, second);
    write_reg(`HUB_REG_STATUS, 32'h8);
    expect_reg("STATUS after overrun clear", `HUB_REG_STATUS, 32'h1);
    issue(CMD_ABORT, bus, err);
    check_bit("pslverr on ABORT", err, 1'b0);
    expect_reg("STATUS after ABORT", `HUB_REG_STATUS, 32'h0);
    finish_test("receive_overrun", errs);
  endtask

  task test_busy_abort();
    hub_msg_t              msg;
    hub_msg_t              got;
    logic [`HUB_BUS_W-1:0] bus;
    logic [`HUB_BUS_W-1:0] other;
    logic                  err;
    int                    errs;
    errs = errors;
    msg = rand_msg();
    bus = rand_bus();
    other = bus + `HUB_BUS_W'(1);
    load_msg(msg);
    issue(CMD_SEND, bus, err);
    check_bit("pslverr on SEND", err, 1'b0);
    fork
      capture_frame(bus, got);
      begin
        repeat (20) @(posedge clk_40);
        write_reg(`HUB_REG_TX_DATA, ~msg.data);
        issue(CMD_SEND, other, err);
        check_bit("pslverr on SEND while busy", err, 1'b1);
      end
    join
    check_msg("frame during refused SEND", got, msg);
    wait_status(1, "tx_done");
    write_reg(`HUB_REG_STATUS, 32'h2);
    // Second send gets cut short
    issue(CMD_SEND, bus, err);
    check_bit("pslverr on second SEND", err, 1'b0);
    repeat (40) @(posedge clk_40);
    issue(CMD_ABORT, bus, err);
    check_bit("pslverr on ABORT", err, 1'b0);
    repeat (2) @(negedge clk_40);
    check_bit("tx lines high after ABORT", &tx, 1'b1);
    repeat (FRAME_CYCLES) @(posedge clk_40);
    expect_reg("STATUS after aborted send", `HUB_REG_STATUS, 32'h0);
    finish_test("busy_and_abort", errs);
  endtask

  initial
  begin
    void'($urandom(32'he8b86359));
    rst     = 1'b0;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    rx      = '1;
    repeat (4) @(posedge clk_40);
    rst <= 1'b1;
    test_reset();
    test_send();
    test_listen();
    test_overrun();
    test_busy_abort();
    $display("%0d tests run, %0d failed, %0d check errors, %0d assertion failures",
             tests_run, tests_failed, errors, UUT.u_chk.fail_count);
    if (errors == 0 && UUT.u_chk.fail_count == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- src/hub_apb_regs.sv
`default_nettype none
`include "hub_macros.svh"

module hub_apb_regs import hub_pkg::*; (
  input  logic        clk_40,
  input  logic        rst,
  input  logic [7:0]  paddr,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  hub_link_if.regs    link,
  input  logic        busy,
  output logic        cmd_valid,
  output hub_cmd_e    cmd,
  output logic        irq
);

  logic                  access;
  logic                  wr;
  logic                  mapped;
  logic                  ctrl_wr;
  logic                  refuse;
  logic                  status_busy;
  hub_cmd_e              wr_cmd;
  logic [10:0]           tx_id;
  logic [31:0]           tx_data;
  logic [`HUB_BUS_W-1:0] bus_sel;
  hub_msg_t              rx_hold;
  logic                  tx_done_flag;
  logic                  rx_valid_flag;
  logic                  overrun_flag;

  assign access  = psel & penable;
  assign wr      = access & pwrite;
  assign ctrl_wr = wr && (paddr == `HUB_REG_CTRL);
  assign wr_cmd  = hub_cmd_e'(pwdata[1:0]);

  // Busy until the PHY has really let go of the line
  assign status_busy = busy | link.tx_busy;

  // SEND and LISTEN need an idle hub, ABORT always goes through
  assign refuse    = ctrl_wr && status_busy && (wr_cmd == CMD_SEND || wr_cmd == CMD_LISTEN);
  assign cmd_valid = ctrl_wr && !refuse;
  assign cmd       = wr_cmd;

  assign pready  = 1'b1;
  assign pslverr = access && (!mapped || refuse);
  assign irq     = tx_done_flag | rx_valid_flag;

  assign link.bus_sel = bus_sel;
  assign link.tx_msg  = {tx_id, tx_data};

  // Address decode and read mux
  always_comb
  begin
    mapped = 1'b1;
    prdata = '0;
    case (paddr)
      `HUB_REG_CTRL:    prdata[6:4] = bus_sel;
      `HUB_REG_TX_ID:   prdata[10:0] = tx_id;
      `HUB_REG_TX_DATA: prdata = tx_data;
      `HUB_REG_STATUS:  prdata[3:0] = {overrun_flag, rx_valid_flag, tx_done_flag, status_busy};
      `HUB_REG_RX_ID:   prdata[10:0] = rx_hold.cob_id;
      `HUB_REG_RX_DATA: prdata = rx_hold.data;
      default:          mapped = 1'b0;
    endcase
  end

  // Message registers
  always_ff @(posedge clk_40)
  begin
    if (wr && paddr == `HUB_REG_TX_ID)
      tx_id <= pwdata[10:0];
    if (wr && paddr == `HUB_REG_TX_DATA)
      tx_data <= pwdata;
    // Newest frame always wins
    if (link.rx_done)
      rx_hold <= link.rx_msg;
  end

  // Bus choice and status flags
  always_ff @(posedge clk_40)
  begin
    if (!rst)
    begin
      bus_sel       <= '0;
      tx_done_flag  <= 1'b0;
      rx_valid_flag <= 1'b0;
      overrun_flag  <= 1'b0;
    end
    else
    begin
      if (cmd_valid && (wr_cmd == CMD_SEND || wr_cmd == CMD_LISTEN))
        bus_sel <= pwdata[4+:`HUB_BUS_W];

      if (link.tx_done)
        tx_done_flag <= 1'b1;
      else if (wr && paddr == `HUB_REG_STATUS && pwdata[1])
        tx_done_flag <= 1'b0;

      // Set beats write-one-to-clear and read-to-clear
      if (link.rx_done)
        rx_valid_flag <= 1'b1;
      else if (wr && paddr == `HUB_REG_STATUS && pwdata[2])
        rx_valid_flag <= 1'b0;
      else if (access && !pwrite && paddr == `HUB_REG_RX_DATA)
        rx_valid_flag <= 1'b0;

      if (link.rx_done && rx_valid_flag)
        overrun_flag <= 1'b1;
      else if (wr && paddr == `HUB_REG_STATUS && pwdata[3])
        overrun_flag <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- src/hub_bus_phy.sv
`default_nettype none
`include "hub_macros.svh"

module hub_bus_phy import hub_pkg::*; (
  input  logic                    clk_40,
  input  logic                    rst,
  hub_link_if.phy                 link,
  output logic [`HUB_N_BUSES-1:0] tx,
  input  logic [`HUB_N_BUSES-1:0] rx
);

  localparam int FRAME = `HUB_FRAME_BITS;
  localparam int CNT_W = $clog2(`HUB_BIT_CYCLES);
  localparam int BITS_W = $clog2(`HUB_FRAME_BITS);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`HUB_BIT_CYCLES - 1);
  localparam logic [CNT_W-1:0] CNT_MID = CNT_W'(`HUB_BIT_CYCLES / 2);
  localparam logic [CNT_W-1:0] CNT_ONE = CNT_W'(1);
  localparam logic [BITS_W-1:0] BIT_LAST = BITS_W'(`HUB_FRAME_BITS - 1);

  logic              tx_active;
  logic [FRAME-1:0]  tx_shift;
  logic [CNT_W-1:0]  tx_cnt;
  logic [BITS_W-1:0] tx_bits;
  logic              tx_line;
  logic              rx_s1;
  logic              rx_s2;
  logic              rx_prev;
  logic              rx_armed;
  logic              rx_active;
  logic [FRAME-2:0]  rx_shift;
  logic [CNT_W-1:0]  rx_cnt;
  logic [BITS_W-1:0] rx_bits;

  assign link.tx_busy = tx_active;
  assign tx_line = tx_active ? tx_shift[FRAME-1] : 1'b1;

  // Unselected buses idle high
  always_comb
  begin
    tx = '1;
    tx[link.bus_sel] = tx_line;
  end

  // Transmit bit timing
  always_ff @(posedge clk_40)
  begin
    if (!rst)
    begin
      tx_active    <= 1'b0;
      tx_cnt       <= '0;
      tx_bits      <= '0;
      link.tx_done <= 1'b0;
    end
    else
    begin
      link.tx_done <= 1'b0;
      if (link.abort)
        tx_active <= 1'b0;
      else if (link.start_tx)
      begin
        tx_active <= 1'b1;
        tx_cnt    <= '0;
        tx_bits   <= '0;
      end
      else if (tx_active)
      begin
        tx_cnt <= (tx_cnt == CNT_LAST) ? '0 : tx_cnt + 1'b1;
        if (tx_cnt == CNT_LAST && tx_bits == BIT_LAST)
        begin
          tx_active    <= 1'b0;
          link.tx_done <= 1'b1;
        end
        else if (tx_cnt == CNT_LAST)
          tx_bits <= tx_bits + 1'b1;
      end
    end
  end

  // Start bit, message, stop bit; shifts in ones behind
  always_ff @(posedge clk_40)
  begin
    if (link.start_tx)
      tx_shift <= {1'b0, link.tx_msg, 1'b1};
    else if (tx_active && tx_cnt == CNT_LAST)
      tx_shift <= {tx_shift[FRAME-2:0], 1'b1};
  end

  // Two-flop sync on the selected rx line, plus one for edge detect
  always_ff @(posedge clk_40)
  begin
    if (!rst)
    begin
      rx_s1   <= 1'b1;
      rx_s2   <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_s1   <= rx[link.bus_sel];
      rx_s2   <= rx_s1;
      rx_prev <= rx_s2;
    end
  end

  // Receive control, edge cycle counts as cycle 0 of the start bit
  always_ff @(posedge clk_40)
  begin
    if (!rst)
    begin
      rx_armed     <= 1'b0;
      rx_active    <= 1'b0;
      rx_cnt       <= '0;
      rx_bits      <= '0;
      link.rx_done <= 1'b0;
    end
    else
    begin
      link.rx_done <= 1'b0;
      if (link.abort)
      begin
        rx_armed  <= 1'b0;
        rx_active <= 1'b0;
      end
      else if (link.start_rx)
      begin
        rx_armed  <= 1'b1;
        rx_active <= 1'b0;
      end
      else if (rx_active)
      begin
        rx_cnt <= (rx_cnt == CNT_LAST) ? '0 : rx_cnt + 1'b1;
        if (rx_cnt == CNT_MID)
        begin
          rx_bits <= rx_bits + 1'b1;
          // Glitch, not a real start bit
          if (rx_bits == '0 && rx_s2)
            rx_active <= 1'b0;
          else if (rx_bits == BIT_LAST)
          begin
            rx_active    <= 1'b0;
            link.rx_done <= rx_s2;
          end
        end
      end
      else if (rx_armed && rx_prev && !rx_s2)
      begin
        rx_active <= 1'b1;
        rx_cnt    <= CNT_ONE;
        rx_bits   <= '0;
      end
    end
  end

  // Receive shift register, message kept only with a good stop bit
  always_ff @(posedge clk_40)
  begin
    if (rx_active && rx_cnt == CNT_MID)
    begin
      rx_shift <= {rx_shift[FRAME-3:0], rx_s2};
      if (rx_bits == BIT_LAST && rx_s2)
        link.rx_msg <= rx_shift[FRAME-3:0];
    end
  end

endmodule

`default_nettype wire

//--- src/hub_link_if.sv
`default_nettype none
`include "hub_macros.svh"

interface hub_link_if import hub_pkg::*; ();

  // Command pulses from the controller
  logic start_tx;
  logic start_rx;
  logic abort;

  // Bus choice and outgoing message from the register file
  logic [`HUB_BUS_W-1:0] bus_sel;
  hub_msg_t tx_msg;

  // PHY status
  logic tx_busy;
  logic tx_done;
  logic rx_done;
  hub_msg_t rx_msg;

  modport ctrl (output start_tx, start_rx, abort, input tx_done);

  modport phy (input start_tx, start_rx, abort, bus_sel, tx_msg,
               output tx_busy, tx_done, rx_done, rx_msg);

  modport regs (input tx_busy, tx_done, rx_done, rx_msg, output bus_sel, tx_msg);

endinterface

`default_nettype wire

//--- src/hub_macros.svh
`ifndef HUB_MACROS_SVH
`define HUB_MACROS_SVH

// Serial bus count and bus index width
`define HUB_N_BUSES 8
`define HUB_BUS_W 3

// Line timing, start bit + 43 message bits + stop bit
`define HUB_BIT_CYCLES 4
`define HUB_FRAME_BITS 45

// APB register map
`define HUB_REG_CTRL 8'h00
`define HUB_REG_TX_ID 8'h04
`define HUB_REG_TX_DATA 8'h08
`define HUB_REG_STATUS 8'h0C
`define HUB_REG_RX_ID 8'h10
`define HUB_REG_RX_DATA 8'h14

`endif

//--- src/hub_msg_ctrl.sv
`default_nettype none

module hub_msg_ctrl import hub_pkg::*; (
  input  logic       clk_40,
  input  logic       rst,
  input  logic       cmd_valid,
  input  hub_cmd_e   cmd,
  output hub_state_e state,
  hub_link_if.ctrl   link
);

  always_ff @(posedge clk_40)
  begin
    if (!rst)
    begin
      state         <= ST_IDLE;
      link.start_tx <= 1'b0;
      link.start_rx <= 1'b0;
      link.abort    <= 1'b0;
    end
    else
    begin
      // Pulses last one cycle only
      link.start_tx <= 1'b0;
      link.start_rx <= 1'b0;
      link.abort    <= 1'b0;

      case (state)
        ST_IDLE:
        begin
          if (cmd_valid && cmd == CMD_SEND)
          begin
            state         <= ST_SEND;
            link.start_tx <= 1'b1;
          end
          else if (cmd_valid && cmd == CMD_LISTEN)
          begin
            state         <= ST_LISTEN;
            link.start_rx <= 1'b1;
          end
        end
        ST_SEND:
        begin
          // Frame finished on the line
          if (link.tx_done)
            state <= ST_IDLE;
        end
        ST_LISTEN:
        begin
          // Stays armed, only ABORT gets out of here
          state <= ST_LISTEN;
        end
        default:
        begin
          state <= ST_IDLE;
        end
      endcase

      // ABORT overrides whatever the state did above
      if (cmd_valid && cmd == CMD_ABORT)
      begin
        state      <= ST_IDLE;
        link.abort <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/hub_pkg.sv
`default_nettype none

package hub_pkg;

  // Opcode field of the CTRL register
  typedef enum logic [1:0]
  {
    CMD_NOP    = 2'd0,
    CMD_SEND   = 2'd1,
    CMD_LISTEN = 2'd2,
    CMD_ABORT  = 2'd3
  } hub_cmd_e;

  // Controller state
  typedef enum logic [1:0]
  {
    ST_IDLE   = 2'd0,
    ST_SEND   = 2'd1,
    ST_LISTEN = 2'd2
  } hub_state_e;

  // Message as it goes on the wire, id first and MSB first
  typedef struct packed
  {
    logic [10:0] cob_id;
    logic [31:0] data;
  } hub_msg_t;

endpackage

`default_nettype wire

//--- src/mopshub_lite.sv
`default_nettype none
`include "hub_macros.svh"

module mopshub_lite import hub_pkg::*; (
  input  logic                    clk_40,
  input  logic                    rst,
  input  logic [7:0]              paddr,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  logic [31:0]             pwdata,
  output logic [31:0]             prdata,
  output logic                    pready,
  output logic                    pslverr,
  output logic [`HUB_N_BUSES-1:0] tx,
  input  logic [`HUB_N_BUSES-1:0] rx,
  output logic                    irq
);

  hub_state_e state;
  hub_cmd_e   cmd;
  logic       cmd_valid;

  hub_link_if link ();

  hub_apb_regs u_regs (
    .clk_40    (clk_40),
    .rst       (rst),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .link      (link),
    .busy      (state != ST_IDLE),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .irq       (irq)
  );

  hub_msg_ctrl u_ctrl (
    .clk_40    (clk_40),
    .rst       (rst),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .state     (state),
    .link      (link)
  );

  hub_bus_phy u_phy (
    .clk_40 (clk_40),
    .rst    (rst),
    .link   (link),
    .tx     (tx),
    .rx     (rx)
  );

endmodule

`default_nettype wire

//--- vlog.f
+incdir+src
src/hub_pkg.sv
src/hub_link_if.sv
src/hub_apb_regs.sv
src/hub_msg_ctrl.sv
src/hub_bus_phy.sv
src/mopshub_lite.sv
sim/mopshub_lite_chk.sv
sim/tb_mopshub_lite.sv
